/* flist.f */
hw/ccm_pkg.sv
hw/ccm_axil_regs.sv
hw/ccm_coe_shadow.sv
hw/ccm_matrix.sv
hw/ccm_top.sv
sim/ccm_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the colour correction testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module ccm_tb -f flist.f -o ccm_tb_sim

./obj_dir/ccm_tb_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0

/* sim/ccm_tb.sv */
module ccm_tb import ccm_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY   = 4;
    localparam int LINES     = 6;
    localparam int LINE_PIX  = 16;
    localparam int TABLE_LEN = 12;

    typedef enum logic [1:0] {OP_FRAME, OP_WRITE, OP_READ} op_t;

    // one row of the stimulus table
    typedef struct packed {
        op_t        op;
        logic       load;
        coe_set_t   coe;
        axil_addr_t addr;
        axil_resp_t resp;
    } entry_t;

    logic      clk;
    logic      reset_i;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    video_t    video_in;
    video_t    video_out;

    entry_t   stim_tab [TABLE_LEN];
    video_t   pix_q [$];
    video_t   exp_q [$];
    coe_set_t model_working;
    coe_set_t model_active;
    logic     model_vs_q;
    integer   seed;
    int       errors;
    int       checks;

    // handshakes seen at the falling edge complete on the next rising edge
    logic       aw_done;
    logic       b_done;
    logic       ar_done;
    logic       r_done;
    axil_addr_t aw_addr;
    axil_data_t aw_data;
    axil_data_t r_data;
    axil_resp_t b_resp;
    axil_resp_t r_resp;

    // row-major Q4.10 coefficients
    int id_vals [9] = '{1024, 0, 0, 0, 1024, 0, 0, 0, 1024};
    // mild correction with gains near 1
    int m1_vals [9] = '{1229, -102, -102, -51, 1126, -51, 0, -205, 1229};
    // strong gains and negative terms drive both clamps
    int m2_vals [9] = '{2048, -1536, 256, -768, 3584, -512, 306, 601, 117};

    ccm_top UUT (
        .clk        (clk),
        .reset_i    (reset_i),
        .axil_req_i (axil_req),
        .axil_rsp_o (axil_rsp),
        .video_i    (video_in),
        .video_o    (video_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic coe_set_t make_coe(input int c [9]);
        coe_set_t m;
        for (int k = 0; k < 9; k++) begin
            m[k] = coe_t'(c[k]);
        end
        return m;
    endfunction

    // word aligned and not past 0x20
    function automatic logic addr_in_map(input axil_addr_t addr);
        return (addr[1:0] == 2'b00) && (addr <= 6'h20);
    endfunction

    // coefficient value as a 32-bit two's complement word
    function automatic axil_data_t sign_extend(input coe_t c);
        return axil_data_t'(int'(c));
    endfunction

    function automatic axil_data_t expected_read(input axil_addr_t addr);
        if (!addr_in_map(addr)) begin
            return '0;
        end
        return sign_extend(model_working[addr[5:2]]);
    endfunction

    // products, add one half, shift by the 10 fraction bits, clamp
    function automatic rgb_t ref_pixel(input coe_set_t m, input rgb_t p);
        int   comp [3];
        int   res [3];
        int   acc;
        coe_t c;
        rgb_t out_px;
        comp[0] = int'(p.r);
        comp[1] = int'(p.g);
        comp[2] = int'(p.b);
        for (int row = 0; row < 3; row++) begin
            acc = 0;
            for (int col = 0; col < 3; col++) begin
                c   = m[3 * row + col];
                acc = acc + int'(c) * comp[col];
            end
            acc = (acc + 512) >>> 10;
            if (acc < 0) begin
                acc = 0;
            end else if (acc > 255) begin
                acc = 255;
            end
            res[row] = acc;
        end
        out_px.r = pixel_t'(res[0]);
        out_px.g = pixel_t'(res[1]);
        out_px.b = pixel_t'(res[2]);
        return out_px;
    endfunction

    function automatic entry_t make_entry(input op_t op, input logic load,
                                          input coe_set_t coe, input axil_addr_t addr,
                                          input axil_resp_t resp);
        entry_t e;
        e.op   = op;
        e.load = load;
        e.coe  = coe;
        e.addr = addr;
        e.resp = resp;
        return e;
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_rgb(input string name, input rgb_t got, input rgb_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_sync(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_data(input string name, input axil_data_t got,
                              input axil_data_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t got,
                              input axil_resp_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, want);
        end
    endtask

    // ----------------------------------------------------------------------
    // one clock of video plus bus bookkeeping
    // ----------------------------------------------------------------------
    task automatic tick();
        video_t v;
        video_t want;
        // bus handshakes sampled mid-cycle
        @(negedge clk);
        aw_done = axil_req.awvalid && axil_req.wvalid && axil_rsp.awready && axil_rsp.wready;
        aw_addr = axil_req.awaddr;
        aw_data = axil_req.wdata;
        b_done  = axil_rsp.bvalid && axil_req.bready;
        b_resp  = axil_rsp.bresp;
        ar_done = axil_req.arvalid && axil_rsp.arready;
        r_done  = axil_rsp.rvalid && axil_req.rready;
        r_data  = axil_rsp.rdata;
        r_resp  = axil_rsp.rresp;
        @(posedge clk);
        #1;
        // register write took effect on this edge
        if (aw_done && addr_in_map(aw_addr)) begin
            model_working[aw_addr[5:2]] = coe_t'(aw_data[13:0]);
        end
        // output now belongs to the pixel driven four ticks ago
        if (exp_q.size() >= LATENCY) begin
            want = exp_q.pop_front();
            check_rgb("video_o.rgb", video_out.rgb, want.rgb);
            check_sync("video_o.de", video_out.de, want.de);
            check_sync("video_o.hs", video_out.hs, want.hs);
            check_sync("video_o.vs", video_out.vs, want.vs);
        end
        if (pix_q.size() > 0) begin
            v = pix_q.pop_front();
        end else begin
            // idle blanking with random data
            v     = '0;
            v.rgb = rgb_t'($random(seed));
        end
        video_in = v;
        want     = v;
        want.rgb = ref_pixel(model_active, v.rgb);
        exp_q.push_back(want);
        // pixel on the vs edge still sees the old set
        if (v.vs && !model_vs_q) begin
            model_active = model_working;
        end
        model_vs_q = v.vs;
    endtask

    // ----------------------------------------------------------------------
    // AXI4-Lite master
    // ----------------------------------------------------------------------
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input axil_resp_t want_resp);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        do begin
            tick();
        end while (!aw_done);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        do begin
            tick();
        end while (!b_done);
        check_resp("bresp", b_resp, want_resp);
    endtask

    task automatic axil_read(input axil_addr_t addr, input axil_data_t want_data,
                             input axil_resp_t want_resp);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        do begin
            tick();
        end while (!ar_done);
        axil_req.arvalid = 1'b0;
        do begin
            tick();
        end while (!r_done);
        check_data("rdata", r_data, want_data);
        check_resp("rresp", r_resp, want_resp);
    endtask

    // vs pulse followed by lines of hs, active pixels and a blank
    task automatic run_frame(input entry_t e);
        video_t v;
        for (int k = 0; k < 3; k++) begin
            v     = '0;
            v.vs  = 1'b1;
            v.rgb = rgb_t'($random(seed));
            pix_q.push_back(v);
        end
        for (int line = 0; line < LINES; line++) begin
            for (int k = 0; k < 2 + LINE_PIX + 1; k++) begin
                v     = '0;
                v.hs  = (k < 2);
                v.de  = (k >= 2) && (k < 2 + LINE_PIX);
                v.rgb = rgb_t'($random(seed));
                pix_q.push_back(v);
            end
        end
        repeat (LATENCY + 8) tick();
        // new matrix lands mid-frame with junk in the upper data bits
        if (e.load) begin
            for (int k = 0; k < COE_COUNT; k++) begin
                axil_write(axil_addr_t'(4 * k), {18'h2d2d2, e.coe[k]}, RESP_OKAY);
            end
            for (int k = 0; k < COE_COUNT; k++) begin
                axil_read(axil_addr_t'(4 * k), sign_extend(e.coe[k]), RESP_OKAY);
            end
        end
        while (pix_q.size() > 0) begin
            tick();
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        seed             = 32'he356f430;
        errors           = 0;
        checks           = 0;
        reset_i          = 1'b1;
        video_in         = '0;
        axil_req         = '0;
        axil_req.bready  = 1'b1;
        axil_req.rready  = 1'b1;
        model_working    = make_coe(id_vals);
        model_active     = make_coe(id_vals);
        model_vs_q       = 1'b0;

        stim_tab[0]  = make_entry(OP_FRAME, 1'b0, make_coe(id_vals), 6'h00, RESP_OKAY);
        stim_tab[1]  = make_entry(OP_FRAME, 1'b1, make_coe(m1_vals), 6'h00, RESP_OKAY);
        stim_tab[2]  = make_entry(OP_FRAME, 1'b1, make_coe(m2_vals), 6'h00, RESP_OKAY);
        stim_tab[3]  = make_entry(OP_FRAME, 1'b0, make_coe(id_vals), 6'h00, RESP_OKAY);
        stim_tab[4]  = make_entry(OP_WRITE, 1'b0, make_coe(id_vals), 6'h24, RESP_SLVERR);
        stim_tab[5]  = make_entry(OP_WRITE, 1'b0, make_coe(id_vals), 6'h01, RESP_SLVERR);
        stim_tab[6]  = make_entry(OP_WRITE, 1'b0, make_coe(id_vals), 6'h3c, RESP_SLVERR);
        stim_tab[7]  = make_entry(OP_READ, 1'b0, make_coe(id_vals), 6'h00, RESP_OKAY);
        stim_tab[8]  = make_entry(OP_READ, 1'b0, make_coe(id_vals), 6'h14, RESP_OKAY);
        stim_tab[9]  = make_entry(OP_READ, 1'b0, make_coe(id_vals), 6'h24, RESP_SLVERR);
        stim_tab[10] = make_entry(OP_READ, 1'b0, make_coe(id_vals), 6'h22, RESP_SLVERR);
        stim_tab[11] = make_entry(OP_FRAME, 1'b0, make_coe(id_vals), 6'h00, RESP_OKAY);

        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;

        for (int i = 0; i < TABLE_LEN; i++) begin
            case (stim_tab[i].op)
                OP_FRAME: run_frame(stim_tab[i]);
                OP_WRITE: axil_write(stim_tab[i].addr, 32'h0000_1fff, stim_tab[i].resp);
                OP_READ:  axil_read(stim_tab[i].addr, expected_read(stim_tab[i].addr),
                                    stim_tab[i].resp);
                default: begin
                    errors++;
                    $display("Unknown table entry %0d", i);
                end
            endcase
        end
        // flush the pixels still in the pipeline
        repeat (LATENCY) tick();

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        repeat (TABLE_LEN * 200 + 1000) @(posedge clk);
        $display("Timeout: the test did not finish within %0d cycles",
                 TABLE_LEN * 200 + 1000);
        $display("Something failed");
        $finish;
    end

endmodule

/* hw/ccm_top.sv */
module ccm_top import ccm_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    input  video_t    video_i,
    output video_t    video_o
);

    // coefficients as the host last wrote them
    coe_set_t working_coe;
    // coefficients in use for the current frame
    coe_set_t active_coe;

    // ----------------------------------------------------------------------
    // host side
    // ----------------------------------------------------------------------
    ccm_axil_regs u_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .axil_req_i    (axil_req_i),
        .axil_rsp_o    (axil_rsp_o),
        .working_coe_o (working_coe)
    );

    // frame start taken from the incoming vs
    ccm_coe_shadow u_shadow (
        .clk           (clk),
        .reset_i       (reset_i),
        .vs_i          (video_i.vs),
        .working_coe_i (working_coe),
        .active_coe_o  (active_coe)
    );

    // ----------------------------------------------------------------------
    // video side
    // ----------------------------------------------------------------------
    ccm_matrix u_matrix (
        .clk          (clk),
        .reset_i      (reset_i),
        .active_coe_i (active_coe),
        .video_i      (video_i),
        .video_o      (video_o)
    );

endmodule

/* hw/ccm_matrix.sv */
module ccm_matrix import ccm_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  coe_set_t active_coe_i,
    input  video_t   video_i,
    output video_t   video_o
);

    // |r'|   | c0 c1 c2 |   |r|
    // |g'| = | c3 c4 c5 | * |g|
    // |b'|   | c6 c7 c8 |   |b|

    pixel_t     comp [3];
    prod_t      prod_q [3][3];
    sum_t       pair_q [3];
    prod_t      third_q [3];
    sum_t       row_q [3];
    rgb_t       out_rgb_q;
    logic [2:0] sync_q [MATRIX_LATENCY];

    // add one half, drop the fraction, clamp to the pixel range
    function automatic pixel_t round_clamp(input sum_t acc);
        sum_t rounded;
        rounded = (acc + ROUND_HALF) >>> COE_FRAC;
        if (rounded[SUM_W-1]) begin
            return '0;
        end else if (rounded > PIXEL_MAX) begin
            return '1;
        end
        return pixel_t'(rounded);
    endfunction

    // column order of the matrix
    assign comp[0] = video_i.rgb.r;
    assign comp[1] = video_i.rgb.g;
    assign comp[2] = video_i.rgb.b;

    // ----------------------------------------------------------------------
    // data pipeline
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int row = 0; row < 3; row++) begin
            // stage 0 forms nine products with the pixel zero-extended to stay positive
            for (int col = 0; col < 3; col++) begin
                prod_q[row][col] <= $signed(active_coe_i[3 * row + col])
                                  * $signed({1'b0, comp[col]});
            end
            // stage 1 adds the first two terms of each row and carries the third
            pair_q[row]  <= sum_t'(prod_q[row][0]) + sum_t'(prod_q[row][1]);
            third_q[row] <= prod_q[row][2];
            // stage 2
            row_q[row]   <= pair_q[row] + sum_t'(third_q[row]);
        end
    end

    // stage 3 round and clamp
    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_rgb_q <= '0;
        end else begin
            out_rgb_q.r <= round_clamp(row_q[0]);
            out_rgb_q.g <= round_clamp(row_q[1]);
            out_rgb_q.b <= round_clamp(row_q[2]);
        end
    end

    // ----------------------------------------------------------------------
    // sync delay
    // ----------------------------------------------------------------------
    // de, hs, vs follow the data through the same number of stages
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 0; k < MATRIX_LATENCY; k++) begin
                sync_q[k] <= '0;
            end
        end else begin
            sync_q[0] <= {video_i.de, video_i.hs, video_i.vs};
            for (int k = 1; k < MATRIX_LATENCY; k++) begin
                sync_q[k] <= sync_q[k-1];
            end
        end
    end

    always_comb begin
        video_o.rgb = out_rgb_q;
        video_o.de  = sync_q[MATRIX_LATENCY-1][2];
        video_o.hs  = sync_q[MATRIX_LATENCY-1][1];
        video_o.vs  = sync_q[MATRIX_LATENCY-1][0];
    end

endmodule

/* hw/ccm_coe_shadow.sv */
module ccm_coe_shadow import ccm_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     vs_i,
    input  coe_set_t working_coe_i,
    output coe_set_t active_coe_o
);

    logic vs_q;
    logic vs_rise;

    // ----------------------------------------------------------------------
    // frame start detect
    // ----------------------------------------------------------------------
    // vs high now, low one cycle ago
    assign vs_rise = vs_i && !vs_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vs_q <= 1'b0;
        end else begin
            vs_q <= vs_i;
        end
    end

    // ----------------------------------------------------------------------
    // active coefficient set
    // ----------------------------------------------------------------------
    // whole matrix swapped in one clock, so host writes made mid-frame
    // never mix with the matrix in use
    // the pixel after the edge is the first one to see the new set
    always_ff @(posedge clk) begin
        if (reset_i) begin
            active_coe_o <= COE_RESET;
        end else if (vs_rise) begin
            active_coe_o <= working_coe_i;
        end
    end

endmodule

/* hw/ccm_axil_regs.sv */
module ccm_axil_regs import ccm_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    output coe_set_t  working_coe_o
);

    // one response machine for writes, one for reads
    typedef enum logic {IDLE, RESP} resp_state_t;

    resp_state_t wr_state;
    resp_state_t rd_state;
    logic        wr_fire;
    logic        rd_fire;
    logic        wr_err;
    logic        rd_err;
    coe_idx_t    wr_idx;
    coe_idx_t    rd_idx;
    coe_t        rd_coe;
    axil_resp_t  bresp_q;
    axil_resp_t  rresp_q;
    axil_data_t  rdata_q;

    // misaligned or past the last coefficient
    function automatic logic addr_bad(input axil_addr_t addr);
        return (addr[1:0] != 2'b00) || (addr > COE_ADDR_LAST);
    endfunction

    // ----------------------------------------------------------------------
    // address decode
    // ----------------------------------------------------------------------
    // aw and w are taken together, only with no write response pending
    assign wr_fire = (wr_state == IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
    assign rd_fire = (rd_state == IDLE) && axil_req_i.arvalid;

    assign wr_err = addr_bad(axil_req_i.awaddr);
    assign rd_err = addr_bad(axil_req_i.araddr);

    // word index from the byte address
    assign wr_idx = coe_idx_t'(axil_req_i.awaddr[AXIL_ADDR_W-1:2]);
    assign rd_idx = coe_idx_t'(axil_req_i.araddr[AXIL_ADDR_W-1:2]);
    assign rd_coe = working_coe_o[rd_idx];

    // ----------------------------------------------------------------------
    // write side
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_state      <= IDLE;
            working_coe_o <= COE_RESET;
        end else begin
            case (wr_state)
                IDLE: begin
                    if (wr_fire) begin
                        // a bad address leaves the registers alone
                        if (!wr_err) begin
                            working_coe_o[wr_idx] <= coe_t'(axil_req_i.wdata[COE_W-1:0]);
                        end
                        wr_state <= RESP;
                    end
                end
                RESP: begin
                    // hold bvalid until the master takes it
                    if (axil_req_i.bready) begin
                        wr_state <= IDLE;
                    end
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // read side
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_state <= IDLE;
        end else begin
            case (rd_state)
                IDLE: begin
                    if (rd_fire) begin
                        rd_state <= RESP;
                    end
                end
                RESP: begin
                    if (axil_req_i.rready) begin
                        rd_state <= IDLE;
                    end
                end
            endcase
        end
    end

    // response payload, captured on acceptance
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
        if (rd_fire) begin
            rresp_q <= rd_err ? RESP_SLVERR : RESP_OKAY;
            // sign-extend the coefficient, zero on error
            if (rd_err) begin
                rdata_q <= '0;
            end else begin
                rdata_q <= {{(AXIL_DATA_W - COE_W){rd_coe[COE_W-1]}}, rd_coe};
            end
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_fire;
        axil_rsp_o.wready  = wr_fire;
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.bvalid  = (wr_state == RESP);
        axil_rsp_o.arready = rd_fire;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
        axil_rsp_o.rvalid  = (rd_state == RESP);
    end

endmodule

/* hw/ccm_pkg.sv */
package ccm_pkg;

    // ----------------------------------------------------------------------
    // widths and fixed-point format
    // ----------------------------------------------------------------------
    localparam int PIXEL_W        = 8;
    localparam int PIXEL_MAX      = (1 << PIXEL_W) - 1;
    localparam int COE_W          = 14;
    // Q4.10, so 1024 means a gain of 1.0
    localparam int COE_FRAC       = 10;
    localparam int COE_COUNT      = 9;
    localparam int COE_IDX_W      = $clog2(COE_COUNT);
    // signed coefficient times zero-extended pixel
    localparam int PROD_W         = COE_W + PIXEL_W + 1;
    // headroom for three products
    localparam int SUM_W          = PROD_W + 2;
    localparam int MATRIX_LATENCY = 4;

    // ----------------------------------------------------------------------
    // AXI4-Lite register map
    // ----------------------------------------------------------------------
    localparam int AXIL_ADDR_W = 6;
    localparam int AXIL_DATA_W = 32;

    typedef logic        [PIXEL_W-1:0]     pixel_t;
    typedef logic signed [COE_W-1:0]       coe_t;
    typedef coe_t        [COE_COUNT-1:0]   coe_set_t;
    typedef logic        [COE_IDX_W-1:0]   coe_idx_t;
    typedef logic signed [PROD_W-1:0]      prod_t;
    typedef logic signed [SUM_W-1:0]       sum_t;
    typedef logic        [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic        [AXIL_DATA_W-1:0] axil_data_t;
    typedef logic        [1:0]             axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // coefficient k lives at byte address 4k, last one at 0x20
    localparam axil_addr_t COE_ADDR_LAST = axil_addr_t'(4 * (COE_COUNT - 1));

    // identity matrix, row-major
    localparam coe_t     COE_ONE   = coe_t'(1 << COE_FRAC);
    localparam coe_set_t COE_RESET = '{COE_ONE, coe_t'(0), coe_t'(0),
                                       coe_t'(0), COE_ONE, coe_t'(0),
                                       coe_t'(0), coe_t'(0), COE_ONE};

    // 0.5 in Q4.10 for round to nearest
    localparam sum_t ROUND_HALF = sum_t'(1 << (COE_FRAC - 1));

    typedef struct packed {
        pixel_t r;
        pixel_t g;
        pixel_t b;
    } rgb_t;

    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic hs;
        logic vs;
    } video_t;

    // master to slave
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

endpackage
